// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

   // Data path and register index widths
   localparam int XLEN   = 32;
   localparam int REG_AW = 5;

   // Major opcodes, instruction bits [6:0]
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;

   // funct3 codes shared by the register and immediate forms
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // Field positions inside the instruction word
   localparam int OPC_LSB = 0;
   localparam int RD_LSB  = 7;
   localparam int F3_LSB  = 12;
   localparam int RS1_LSB = 15;
   localparam int RS2_LSB = 20;
   localparam int IMM_I_LSB = 20;
   localparam int IMM_U_LSB = 12;

   // funct7 bit that turns ADD into SUB
   localparam int SUB_BIT = 30;

endpackage

// File: hw/core_cfg_pkg.sv
package core_cfg_pkg;

   import rv_isa_pkg::*;

   // One bit per cycle over XLEN cycles
   localparam int CNT_W = 5;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_XOR    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_AND    = 3'd4,
      ALU_PASS_B = 3'd5
   } alu_op_t;

   typedef enum logic [1:0] {
      PH_FETCH  = 2'd0,
      PH_EXEC   = 2'd1,
      PH_RETIRE = 2'd2
   } seq_phase_t;

   // Decoded instruction, held stable from ack until the next fetch
   typedef struct packed {
      alu_op_t           operation;
      logic [REG_AW-1:0] rd;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      logic              use_imm;
      logic              rd_wen;
      logic [XLEN-1:0]   imm;
   } dec_insn_t;

endpackage

// File: hw/core_ifs.sv
`timescale 1ns/1ns

// Bit step and decoded instruction, from the sequencer to RF and ALU
interface serial_step_if import core_cfg_pkg::*;;

   logic             cnt_en;
   logic [CNT_W-1:0] cnt;
   logic             cnt_done;
   dec_insn_t        dec;
   logic             imm_bit;

   modport producer (
      output cnt_en,
      output cnt,
      output cnt_done,
      output dec,
      output imm_bit
   );

   modport consumer (
      input cnt_en,
      input cnt,
      input cnt_done,
      input dec,
      input imm_bit
   );

endinterface

// Single-bit operand and result lanes between RF and ALU
interface rf_bit_if;

   logic rs1_bit;
   logic rs2_bit;
   logic rd_bit;
   logic rd_we;

   modport rf (
      output rs1_bit,
      output rs2_bit,
      input  rd_bit,
      input  rd_we
   );

   modport alu (
      input  rs1_bit,
      input  rs2_bit,
      output rd_bit,
      output rd_we
   );

endinterface

// File: hw/insn_seq_decode.sv
`timescale 1ns/1ns

module insn_seq_decode
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;
#(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  logic            clk,
   input  logic            i_rst,
   input  logic [XLEN-1:0] i_ibus_rdt,
   input  logic            i_ibus_ack,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   output logic            o_trace_valid,
   output logic [XLEN-1:0] o_trace_pc,
   output logic [XLEN-1:0] o_trace_insn,
   serial_step_if.producer step
);

   seq_phase_t       phase_q;
   logic             cyc_q;
   logic [CNT_W-1:0] cnt_q;
   logic [XLEN-1:0]  pc_q;
   logic [XLEN-1:0]  insn_q;
   logic             fetch_done;
   logic             last_bit;
   logic [6:0]       opcode;
   logic [2:0]       funct3;
   logic             f3_known;
   dec_insn_t        dec;

   assign fetch_done = cyc_q & i_ibus_ack;
   assign last_bit   = (phase_q == PH_EXEC) && (cnt_q == CNT_W'(XLEN - 1));

   // FETCH until ack, 32 EXEC cycles, then one RETIRE cycle
   always_ff @(posedge clk) begin
      if (i_rst) begin
         phase_q <= PH_FETCH;
         cyc_q   <= 1'b0;
         cnt_q   <= '0;
         pc_q    <= RESET_PC;
      end else begin
         case (phase_q)
            PH_FETCH: begin
               if (fetch_done) begin
                  cyc_q   <= 1'b0;
                  phase_q <= PH_EXEC;
               end else begin
                  cyc_q <= 1'b1;
               end
            end
            PH_EXEC: begin
               // Wraps back to 0 after the last bit
               cnt_q <= cnt_q + CNT_W'(1);
               if (last_bit) begin
                  phase_q <= PH_RETIRE;
               end
            end
            PH_RETIRE: begin
               pc_q    <= pc_q + XLEN'(4);
               cyc_q   <= 1'b1;
               phase_q <= PH_FETCH;
            end
            default: phase_q <= PH_FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_done) begin
         insn_q <= i_ibus_rdt;
      end
   end

   always_comb begin
      opcode = insn_q[OPC_LSB +: 7];
      funct3 = insn_q[F3_LSB +: 3];

      dec.rd      = insn_q[RD_LSB +: REG_AW];
      dec.rs1     = insn_q[RS1_LSB +: REG_AW];
      dec.rs2     = insn_q[RS2_LSB +: REG_AW];
      dec.use_imm = 1'b0;
      dec.imm     = {{(XLEN - 12){insn_q[XLEN-1]}}, insn_q[IMM_I_LSB +: 12]};

      f3_known = 1'b1;
      case (funct3)
         F3_ADD_SUB: dec.operation = ALU_ADD;
         F3_XOR:     dec.operation = ALU_XOR;
         F3_OR:      dec.operation = ALU_OR;
         F3_AND:     dec.operation = ALU_AND;
         default: begin
            dec.operation = ALU_ADD;
            f3_known      = 1'b0;
         end
      endcase

      case (opcode)
         OPC_OP: begin
            if (funct3 == F3_ADD_SUB && insn_q[SUB_BIT]) begin
               dec.operation = ALU_SUB;
            end
            dec.rd_wen = f3_known;
         end
         OPC_OP_IMM: begin
            dec.use_imm = 1'b1;
            dec.rd_wen  = f3_known;
         end
         OPC_LUI: begin
            dec.operation = ALU_PASS_B;
            dec.use_imm   = 1'b1;
            dec.imm       = {insn_q[XLEN-1:IMM_U_LSB], {IMM_U_LSB{1'b0}}};
            dec.rd_wen    = 1'b1;
         end
         // Everything else retires as a no-op
         default: dec.rd_wen = 1'b0;
      endcase

      if (dec.rd == '0) begin
         dec.rd_wen = 1'b0;
      end
   end

   assign step.cnt_en   = (phase_q == PH_EXEC);
   assign step.cnt      = cnt_q;
   assign step.cnt_done = last_bit;
   assign step.dec      = dec;
   assign step.imm_bit  = dec.imm[cnt_q];

   assign o_ibus_adr    = pc_q;
   assign o_ibus_cyc    = cyc_q;
   assign o_trace_valid = (phase_q == PH_RETIRE);
   assign o_trace_pc    = pc_q;
   assign o_trace_insn  = insn_q;

endmodule

// File: hw/serial_rf.sv
`timescale 1ns/1ns

module serial_rf
   import rv_isa_pkg::*;
(
   input  logic clk,
   input  logic i_rst,
   serial_step_if.consumer step,
   rf_bit_if.rf            rfb
);

   localparam int NREGS = 2 ** REG_AW;

   logic [XLEN-1:0] regs [NREGS];
   logic            rs1_nz;
   logic            rs2_nz;

   assign rs1_nz = (step.dec.rs1 != '0);
   assign rs2_nz = (step.dec.rs2 != '0);

   // Old bit is seen on the cycle it gets overwritten, so rd == rs1 is safe
   assign rfb.rs1_bit = step.cnt_en & rs1_nz & regs[step.dec.rs1][step.cnt];
   assign rfb.rs2_bit = step.cnt_en & rs2_nz & regs[step.dec.rs2][step.cnt];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rfb.rd_we && step.dec.rd != '0) begin
         regs[step.dec.rd][step.cnt] <= rfb.rd_bit;
      end
   end

endmodule

// File: hw/serial_alu.sv
`timescale 1ns/1ns

module serial_alu
   import rv_isa_pkg::*;
   import core_cfg_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst,
   serial_step_if.consumer   step,
   rf_bit_if.alu             rfb,
   output logic [REG_AW-1:0] o_trace_rd_addr,
   output logic [XLEN-1:0]   o_trace_rd_wdata
);

   logic              op_a;
   logic              op_b;
   logic              is_sub;
   logic              b_in;
   logic              carry_in;
   logic              carry_q;
   logic              sum;
   logic              result;
   logic [XLEN-1:0]   wdata_q;
   logic [XLEN-1:0]   wdata_next;
   logic [REG_AW-1:0] trace_rd_q;
   logic [XLEN-1:0]   trace_wdata_q;

   assign op_a   = rfb.rs1_bit;
   assign op_b   = step.dec.use_imm ? step.imm_bit : rfb.rs2_bit;
   assign is_sub = (step.dec.operation == ALU_SUB);

   // Subtract is A + ~B + 1 with the +1 as the first carry
   assign b_in     = op_b ^ is_sub;
   assign carry_in = (step.cnt == '0) ? is_sub : carry_q;
   assign sum      = op_a ^ b_in ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         carry_q <= 1'b0;
      end else if (step.cnt_en) begin
         carry_q <= (op_a & b_in) | (op_a & carry_in) | (b_in & carry_in);
      end
   end

   always_comb begin
      case (step.dec.operation)
         ALU_ADD,
         ALU_SUB:    result = sum;
         ALU_XOR:    result = op_a ^ op_b;
         ALU_OR:     result = op_a | op_b;
         ALU_AND:    result = op_a & op_b;
         ALU_PASS_B: result = op_b;
         default:    result = 1'b0;
      endcase
   end

   assign rfb.rd_bit = result;
   assign rfb.rd_we  = step.cnt_en & step.dec.rd_wen;

   // LSB first so the word is aligned after the last bit
   assign wdata_next = {result, wdata_q[XLEN-1:1]};

   always_ff @(posedge clk) begin
      if (rfb.rd_we) begin
         wdata_q <= wdata_next;
      end
   end

   // Finished word captured on the last bit
   always_ff @(posedge clk) begin
      if (i_rst) begin
         trace_rd_q    <= '0;
         trace_wdata_q <= '0;
      end else if (step.cnt_done) begin
         trace_rd_q    <= step.dec.rd_wen ? step.dec.rd : '0;
         trace_wdata_q <= step.dec.rd_wen ? wdata_next : '0;
      end
   end

   assign o_trace_rd_addr  = trace_rd_q;
   assign o_trace_rd_wdata = trace_wdata_q;

endmodule

// File: hw/serial_core_top.sv
`timescale 1ns/1ns

module serial_core_top
   import rv_isa_pkg::*;
#(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  logic              clk,
   input  logic              i_rst,

   // Instruction bus
   output logic [XLEN-1:0]   o_ibus_adr,
   output logic              o_ibus_cyc,
   input  logic [XLEN-1:0]   i_ibus_rdt,
   input  logic              i_ibus_ack,

   // Retire trace
   output logic              o_trace_valid,
   output logic [XLEN-1:0]   o_trace_pc,
   output logic [XLEN-1:0]   o_trace_insn,
   output logic [REG_AW-1:0] o_trace_rd_addr,
   output logic [XLEN-1:0]   o_trace_rd_wdata
);

   serial_step_if step_if ();
   rf_bit_if      bit_if ();

   insn_seq_decode #(
      .RESET_PC (RESET_PC)
   ) seq_i (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_ibus_rdt    (i_ibus_rdt),
      .i_ibus_ack    (i_ibus_ack),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_trace_valid (o_trace_valid),
      .o_trace_pc    (o_trace_pc),
      .o_trace_insn  (o_trace_insn),
      .step          (step_if.producer)
   );

   serial_rf rf_i (
      .clk   (clk),
      .i_rst (i_rst),
      .step  (step_if.consumer),
      .rfb   (bit_if.rf)
   );

   serial_alu alu_i (
      .clk              (clk),
      .i_rst            (i_rst),
      .step             (step_if.consumer),
      .rfb              (bit_if.alu),
      .o_trace_rd_addr  (o_trace_rd_addr),
      .o_trace_rd_wdata (o_trace_rd_wdata)
   );

endmodule

// File: dv/tb_serial_core.sv
`timescale 1ns/1ns

module tb_serial_core;

   localparam int          NUM_VEC     = 28;
   localparam int          CLK_PERIOD  = 100;
   localparam logic [31:0] RESET_PC    = 32'h0000_0100;
   localparam logic [31:0] SEED        = 32'ha52466ac;
   localparam int          ACK_LATENCY = 33;
   // 40 cycles per instruction is well above fetch delay plus execute
   localparam longint      WATCHDOG_NS = longint'(NUM_VEC) * 40 * CLK_PERIOD * 2;

   logic        clk;
   logic        i_rst;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic        o_trace_valid;
   logic [31:0] o_trace_pc;
   logic [31:0] o_trace_insn;
   logic [4:0]  o_trace_rd_addr;
   logic [31:0] o_trace_rd_wdata;

   // Three words per vector: insn, rd address, rd data
   logic [31:0] vec_mem [0:3*NUM_VEC-1];

   serial_core_top #(
      .RESET_PC (RESET_PC)
   ) dut_i (
      .clk              (clk),
      .i_rst            (i_rst),
      .o_ibus_adr       (o_ibus_adr),
      .o_ibus_cyc       (o_ibus_cyc),
      .i_ibus_rdt       (i_ibus_rdt),
      .i_ibus_ack       (i_ibus_ack),
      .o_trace_valid    (o_trace_valid),
      .o_trace_pc       (o_trace_pc),
      .o_trace_insn     (o_trace_insn),
      .o_trace_rd_addr  (o_trace_rd_addr),
      .o_trace_rd_wdata (o_trace_rd_wdata)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   // Acts as instruction memory for one word, then checks its retire
   task automatic run_vector(input int idx);
      logic [31:0] insn;
      logic [31:0] exp_pc;
      logic [31:0] wait_cnt;
      int          delay;
      insn     = vec_mem[3*idx];
      exp_pc   = RESET_PC + 32'(4 * idx);
      delay    = int'($urandom % 4);
      wait_cnt = '0;

      // Request is up on the first cycle after reset or retire
      @(negedge clk);
      check_val("o_ibus_cyc", 32'(o_ibus_cyc), 32'd1);
      check_val("o_trace_valid", 32'(o_trace_valid), 32'd0);
      check_val("o_ibus_adr", o_ibus_adr, exp_pc);
      repeat (delay) begin
         @(negedge clk);
         check_val("o_ibus_cyc", 32'(o_ibus_cyc), 32'd1);
         check_val("o_ibus_adr", o_ibus_adr, exp_pc);
      end
      i_ibus_ack = 1'b1;
      i_ibus_rdt = insn;

      // Count from the ack edge to the trace pulse
      do begin
         @(negedge clk);
         check_val("o_ibus_cyc", 32'(o_ibus_cyc), 32'd0);
         i_ibus_ack = 1'b0;
         // Junk on the bus must not reach the latched word
         i_ibus_rdt = ~insn;
         wait_cnt   = wait_cnt + 32'd1;
      end while (!o_trace_valid);

      check_val("trace_latency_cycles", wait_cnt, 32'(ACK_LATENCY));
      check_val("o_trace_pc", o_trace_pc, exp_pc);
      check_val("o_trace_insn", o_trace_insn, insn);
      check_val("o_trace_rd_addr", 32'(o_trace_rd_addr), vec_mem[3*idx+1]);
      check_val("o_trace_rd_wdata", o_trace_rd_wdata, vec_mem[3*idx+2]);
   endtask

   initial begin
      void'($urandom(SEED));
      i_rst      = 1'b1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;

      for (int i = 0; i < 3 * NUM_VEC; i++) begin
         vec_mem[i] = {16'hBAD0, 16'(i)};
      end
      $readmemh("dv/serial_core_vectors.txt", vec_mem);
      if (vec_mem[3*NUM_VEC-1] === {16'hBAD0, 16'(3 * NUM_VEC - 1)}) begin
         $display("vector file could not be read or holds too few entries");
         $display("TB FAILED");
         $fatal(1);
      end

      // Bus and trace stay quiet while reset is held
      repeat (3) begin
         @(negedge clk);
         check_val("o_ibus_cyc", 32'(o_ibus_cyc), 32'd0);
         check_val("o_trace_valid", 32'(o_trace_valid), 32'd0);
      end
      i_rst = 1'b0;

      for (int i = 0; i < NUM_VEC; i++) begin
         run_vector(i);
      end

      $display("TB PASSED");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before all instructions retired");
      $display("TB FAILED");
      $fatal(1);
   end

endmodule

// File: files.f
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/core_ifs.sv
hw/insn_seq_decode.sv
hw/serial_rf.sv
hw/serial_alu.sv
hw/serial_core_top.sv
dv/tb_serial_core.sv

// File: run.sh
#!/bin/sh
# Build and run the serial core testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
   --top-module tb_serial_core \
   --Mdir "$BUILD_DIR" \
   -o tb_serial_core \
   -f files.f

# The log decides the outcome, so a nonzero exit of the run is tolerated here
"./$BUILD_DIR/tb_serial_core" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
   echo "simulation failed, see $LOG"
   exit 1
fi
echo "simulation passed"

// File: dv/serial_core_vectors.txt
// insn     rd  rd_data   (one instruction per line, all hex)
// rd and rd_data are what the trace must show when the instruction retires
123450B7 01 12345000
67808093 01 12345678
FFF00113 02 FFFFFFFF
00100193 03 00000001
00310233 04 00000000
403002B3 05 FFFFFFFF
40208333 06 12345679
F0F0F3B7 07 F0F0F000
0F038393 07 F0F0F0F0
0070C433 08 E2C4A688
0070E4B3 09 F2F4F6F8
0070F533 0A 10305070
FFF0C593 0B EDCBA987
7F01E613 0C 000007F1
80017693 0D FFFFF800
00508013 00 00000000
ABCDE037 00 00000000
0020A023 00 00000000
00000000 00 00000000
0020A733 00 00000000
00300733 0E 00000001
403080B3 01 12345677
002107B3 0F FFFFFFFE
80000813 10 FFFFF800
010088B3 11 12344E77
0010C0B3 01 00000000
00308933 12 00000001
402189B3 13 00000002
